// ==== cf_engine.f ====
verilog/cf_pkg.sv
verilog/ratio_bus_if.sv
verilog/sweep_ctrl.sv
verilog/gain_divider.sv
verilog/cost_accum.sv
verilog/cf_engine.sv
tb/cf_engine_sva.sv
tb/cf_checker.sv
tb/cf_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cf_engine testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cf_engine_tb \
        -f cf_engine.f -o cf_engine_sim

# the exit status is that of grep, so a missing pass line fails the script
./obj_dir/cf_engine_sim +verilator+error+limit+1000 | tee /dev/stderr | \
        grep -q "Simulation PASSED"

echo "run_sim: done"

// ==== tb/cf_engine_tb.sv ====
/* top testbench of the cost engine; drives fixed and random sweeps into the DUT
   and prints the error counts and the final verdict */
`timescale 1ns/1ps

module cf_engine_tb;
        import cf_pkg::*;

        logic        clk;
        logic        rst;
        logic        sample_valid;
        sample_t     sample_i;
        sample_t     sample_q;
        logic        sample_ready;
        logic        ratio_valid;
        tone_t       ratio_tone;
        ratio_t      ratio_value;
        logic        cost_valid;
        cost_t       cost_value;
        logic        sweep_busy;

        logic [31:0] lfsr;
        int          chk_errors;
        int          ratio_checks;
        int          cost_checks;
        int          tb_errors;
        int          timeouts;
        int          sweeps;
        bit          aborted;
        cost_t       cost;
        sample_t     r [4];
        logic [7:0]  shift;

        cf_engine cf_engine_i (
                .clk          (clk),
                .rst          (rst),
                .sample_valid (sample_valid),
                .sample_i     (sample_i),
                .sample_q     (sample_q),
                .sample_ready (sample_ready),
                .ratio_valid  (ratio_valid),
                .ratio_tone   (ratio_tone),
                .ratio_value  (ratio_value),
                .cost_valid   (cost_valid),
                .cost_value   (cost_value),
                .sweep_busy   (sweep_busy)
        );

        cf_checker checker_i (
                .clk          (clk),
                .rst          (rst),
                .sample_valid (sample_valid),
                .sample_i     (sample_i),
                .sample_q     (sample_q),
                .sample_ready (sample_ready),
                .ratio_valid  (ratio_valid),
                .ratio_tone   (ratio_tone),
                .ratio_value  (ratio_value),
                .cost_valid   (cost_valid),
                .cost_value   (cost_value),
                .sweep_busy   (sweep_busy),
                .errors       (chk_errors),
                .ratio_checks (ratio_checks),
                .cost_checks  (cost_checks)
        );

        always #5 clk = ~clk;

        // --------------------------------------------------
        // stimulus helpers
        // --------------------------------------------------
        // taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        // one lfsr step per bit taken
        task automatic rand_bits(input int n, output logic [7:0] v);
                v = '0;
                for (int k = 0; k < n; k++) begin
                        lfsr = lfsr_next(lfsr);
                        v = {v[6:0], lfsr[0]};
                end
        endtask

        // holds sample_valid until the engine takes the sample
        task automatic send_sample(input sample_t i, input sample_t q);
                int n;
                if (aborted)
                        return;
                sample_valid = 1'b1;
                sample_i     = i;
                sample_q     = q;
                n = 0;
                while (!sample_ready && n < 100) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (!sample_ready) begin
                        $display("timeout: sample_ready stayed low for %0d cycles", n);
                        timeouts++;
                        aborted = 1'b1;
                end else begin
                        @(posedge clk);
                        #1;
                end
                sample_valid = 1'b0;
        endtask

        // stray strobe while a division is running
        task automatic poke_while_busy();
                if (aborted)
                        return;
                if (sample_ready) begin
                        $display("[ERROR] %0t: sample_ready high during a division", $time);
                        tb_errors++;
                end
                sample_valid = 1'b1;
                sample_i     = 8'sd90;
                sample_q     = -8'sd100;
                @(posedge clk);
                #1;
                sample_valid = 1'b0;
        endtask

        task automatic send_pair(input sample_t oi, input sample_t oq,
                                 input sample_t ii, input sample_t iq, input bit poke);
                send_sample(oi, oq);
                send_sample(ii, iq);
                if (poke)
                        poke_while_busy();
        endtask

        task automatic wait_cost(output cost_t c);
                int n;
                c = '0;
                if (aborted)
                        return;
                n = 0;
                while (!cost_valid && n < 200) begin
                        @(posedge clk);
                        #1;
                        n++;
                end
                if (cost_valid) begin
                        c = cost_value;
                end else begin
                        $display("timeout: no cost_valid within %0d cycles", n);
                        timeouts++;
                        aborted = 1'b1;
                end
        endtask

        // --------------------------------------------------
        // test sequence
        // --------------------------------------------------
        initial begin
                clk          = 1'b0;
                rst          = 1'b1;
                sample_valid = 1'b0;
                sample_i     = '0;
                sample_q     = '0;
                lfsr         = 32'hca49_9c42;
                tb_errors    = 0;
                timeouts     = 0;
                sweeps       = 0;
                aborted      = 1'b0;
                repeat (16) @(posedge clk);
                #1;
                rst = 1'b0;

                // idle engine: ready, not busy, no strobes
                repeat (6) begin
                        @(posedge clk);
                        #1;
                        if (!sample_ready || ratio_valid || cost_valid || sweep_busy) begin
                                $display("[ERROR] %0t: idle ready=%b ratio=%b cost=%b busy=%b",
                                         $time, sample_ready, ratio_valid, cost_valid, sweep_busy);
                                tb_errors++;
                        end
                end

                // equal magnitudes, all ratios at unity
                send_pair(8'sd40, -8'sd20, -8'sd20, 8'sd40, 1'b0);
                send_pair(8'sd0, 8'sd90, -8'sd90, 8'sd0, 1'b0);
                send_pair(8'sd100, 8'sd100, -8'sd100, -8'sd100, 1'b0);
                send_pair(8'sh80, 8'sd0, 8'sd0, 8'sh80, 1'b0);
                wait_cost(cost);
                sweeps++;
                // two tilt terms of 128 - 53 each
                if (!aborted && cost != 8'd150) begin
                        $display("[ERROR] %0t: unity sweep cost %0d, expected 150", $time, cost);
                        tb_errors++;
                end

                // zero input magnitudes, stray strobes after every pair
                send_pair(8'sd60, 8'sd0, 8'sd30, 8'sd0, 1'b1);
                send_pair(8'sd50, 8'sd10, 8'sd0, 8'sd0, 1'b1);
                send_pair(8'sd0, 8'sd0, 8'sd0, 8'sd0, 1'b1);
                send_pair(-8'sd64, 8'sd32, 8'sd100, 8'sd0, 1'b1);
                wait_cost(cost);
                sweeps++;

                // steep tilt one way, then the other
                send_pair(8'sd127, 8'sd0, 8'sd1, 8'sd0, 1'b0);
                send_pair(8'sd0, 8'sd0, 8'sd64, 8'sd0, 1'b0);
                send_pair(8'sd0, 8'sd0, 8'sd64, 8'sd0, 1'b0);
                send_pair(8'sd0, 8'sd0, 8'sd127, 8'sd127, 1'b0);
                wait_cost(cost);
                sweeps++;
                if (!aborted && cost != 8'd255) begin
                        $display("[ERROR] %0t: tilted sweep cost %0d, expected 255", $time, cost);
                        tb_errors++;
                end
                send_pair(8'sd0, 8'sd0, 8'sd64, 8'sd0, 1'b0);
                send_pair(8'sd127, 8'sd127, 8'sd1, 8'sd0, 1'b0);
                send_pair(8'sd0, 8'sd0, 8'sd5, 8'sd5, 1'b0);
                send_pair(8'sh80, 8'sd0, 8'sd2, 8'sd0, 1'b0);
                wait_cost(cost);
                sweeps++;
                if (!aborted && cost != 8'd255) begin
                        $display("[ERROR] %0t: tilted sweep cost %0d, expected 255", $time, cost);
                        tb_errors++;
                end

                // random sweeps, input shrunk now and then to reach saturation
                repeat (8) begin
                        for (int t = 0; t < 4; t++) begin
                                rand_bits(8, r[0]);
                                rand_bits(8, r[1]);
                                rand_bits(8, r[2]);
                                rand_bits(8, r[3]);
                                rand_bits(2, shift);
                                send_pair(r[0], r[1], r[2] >>> shift, r[3] >>> shift, t[0]);
                        end
                        wait_cost(cost);
                        sweeps++;
                end

                repeat (10) @(posedge clk);
                $write("errors: checker %0d, testbench %0d, timeouts %0d, assertions %0d; ",
                       chk_errors, tb_errors, timeouts, cf_engine_i.sva_i.fails);
                $display("ratios checked %0d, costs checked %0d", ratio_checks, cost_checks);
                if (chk_errors == 0 && tb_errors == 0 && timeouts == 0 &&
                    cf_engine_i.sva_i.fails == 0 && ratio_checks == 4 * sweeps &&
                    cost_checks == sweeps)
                        $display("Simulation PASSED");
                else
                        $display("Simulation FAILED");
                $finish;
        end

endmodule

// ==== tb/cf_checker.sv ====
/* scoreboard of the cost engine; records accepted samples at the DUT ports,
   predicts every ratio and sweep cost and counts mismatches */
`timescale 1ns/1ps

module cf_checker (
        input  logic            clk,
        input  logic            rst,
        input  logic            sample_valid,
        input  cf_pkg::sample_t sample_i,
        input  cf_pkg::sample_t sample_q,
        input  logic            sample_ready,
        input  logic            ratio_valid,
        input  cf_pkg::tone_t   ratio_tone,
        input  cf_pkg::ratio_t  ratio_value,
        input  logic            cost_valid,
        input  cf_pkg::cost_t   cost_value,
        input  logic            sweep_busy,
        output int              errors,
        output int              ratio_checks,
        output int              cost_checks
);
        import cf_pkg::*;

        int exp_ratio [$];
        int exp_tone [$];
        int ratios [n_tones];
        int out_mag;
        bit have_out;
        int next_tone;
        // ratios reported since the last cost
        int seen;
        int mag;
        int want;
        int want_tone;
        // sweep_busy level expected in the current cycle
        bit busy_exp;

        // --------------------------------------------------
        // reference model
        // --------------------------------------------------
        function automatic int est_magnitude(input int i, input int q);
                int a;
                int b;
                a = (i < 0) ? -i : i;
                b = (q < 0) ? -q : q;
                return (a >= b) ? a + b / 2 : b + a / 2;
        endfunction

        function automatic int expected_ratio(input int num, input int den);
                int q;
                if (den == 0)
                        return ratio_max;
                q = (num * (1 << ratio_shift)) / den;
                return (q > ratio_max) ? ratio_max : q;
        endfunction

        function automatic int gap(input int x, input int y);
                return (x > y) ? x - y : y - x;
        endfunction

        function automatic int expected_cost(input int a1, input int a2,
                                             input int a3, input int a4);
                int c;
                c = gap(a3, a1 * tilt_weight / 256) + gap(a1, a4) + gap(a2, a3) +
                    gap(a2, a4 * tilt_weight / 256) + gap(a2, unity_ratio);
                return (c > cost_max) ? cost_max : c;
        endfunction

        // --------------------------------------------------
        // per-cycle checks
        // --------------------------------------------------
        // output sample first, ratio predicted once the input partner arrives
        task automatic record_sample();
                mag = est_magnitude(int'(sample_i), int'(sample_q));
                if (!have_out) begin
                        out_mag  = mag;
                        have_out = 1'b1;
                end else begin
                        exp_ratio.push_back(expected_ratio(out_mag, mag));
                        exp_tone.push_back(next_tone);
                        next_tone = (next_tone + 1) % n_tones;
                        have_out  = 1'b0;
                end
        endtask

        task automatic check_ratio();
                if (exp_ratio.size() == 0) begin
                        $display("ratio strobe at %0t with no sample pair behind it",
                                 $time);
                        errors++;
                        return;
                end
                want      = exp_ratio.pop_front();
                want_tone = exp_tone.pop_front();
                ratios[want_tone] = want;
                seen++;
                ratio_checks++;
                if (int'(ratio_tone) != want_tone || int'(ratio_value) != want) begin
                        $display("[ERROR] %0t: ratio %0d on tone %0d, expected %0d on tone %0d",
                                 $time, ratio_value, ratio_tone, want, want_tone);
                        errors++;
                end
        endtask

        task automatic check_cost();
                if (seen != n_tones) begin
                        $display("cost strobe at %0t after %0d ratios instead of four",
                                 $time, seen);
                        errors++;
                end
                want = expected_cost(ratios[0], ratios[1], ratios[2], ratios[3]);
                seen = 0;
                cost_checks++;
                if (int'(cost_value) != want) begin
                        $display("[ERROR] %0t: cost %0d, expected %0d",
                                 $time, cost_value, want);
                        errors++;
                end
        endtask

        // busy from the first accepted sample through the cost strobe
        task automatic check_busy();
                if (sweep_busy !== busy_exp) begin
                        $display("[ERROR] %0t: sweep_busy %b, expected %b",
                                 $time, sweep_busy, busy_exp);
                        errors++;
                end
        endtask

        // --------------------------------------------------
        // comparison, sampled mid-cycle where ports are settled
        // --------------------------------------------------
        always @(negedge clk) begin
                if (rst) begin
                        exp_ratio.delete();
                        exp_tone.delete();
                        have_out  = 1'b0;
                        next_tone = 0;
                        seen      = 0;
                        busy_exp  = 1'b0;
                end else begin
                        check_busy();
                        if (sample_valid && sample_ready)
                                record_sample();
                        if (ratio_valid)
                                check_ratio();
                        if (cost_valid)
                                check_cost();
                        if (sample_valid && sample_ready)
                                busy_exp = 1'b1;
                        else if (cost_valid)
                                busy_exp = 1'b0;
                end
        end

endmodule

// ==== tb/cf_engine_sva.sv ====
/* protocol assertions on the strobes and the ready level of the engine,
   bound into the top level below */
`timescale 1ns/1ps

module cf_engine_sva (
        input logic clk,
        input logic rst,
        input logic sample_ready,
        input logic ratio_valid,
        input logic cost_valid,
        input logic div_start
);
        // failed assertions so far, read by the testbench at the end
        int fails = 0;

        ratio_pulse_a: assert property (@(posedge clk) disable iff (rst)
                ratio_valid |=> !ratio_valid)
                else begin
                        fails++;
                        $error("ratio_valid high for more than one cycle");
                end

        cost_pulse_a: assert property (@(posedge clk) disable iff (rst)
                cost_valid |=> !cost_valid)
                else begin
                        fails++;
                        $error("cost_valid high for more than one cycle");
                end

        // division or cost sum still running
        ready_busy_a: assert property (@(posedge clk) disable iff (rst)
                (div_start || ratio_valid || cost_valid) |-> !sample_ready)
                else begin
                        fails++;
                        $error("sample_ready high while work is pending");
                end

        reset_quiet_a: assert property (@(posedge clk)
                (rst && $past(rst)) |-> (!ratio_valid && !cost_valid))
                else begin
                        fails++;
                        $error("output strobe during reset");
                end

endmodule

bind cf_engine cf_engine_sva sva_i (
        .clk          (clk),
        .rst          (rst),
        .sample_ready (sample_ready),
        .ratio_valid  (ratio_valid),
        .cost_valid   (cost_valid),
        .div_start    (div_start)
);

// ==== verilog/cf_engine.sv ====
/* top level of the cost engine; samples in, per-tone ratios and the sweep cost out
   connects the sweep controller, the divider and the cost accumulator */
`timescale 1ns/1ps

module cf_engine (
        input  logic            clk,
        input  logic            rst,
        input  logic            sample_valid,
        input  cf_pkg::sample_t sample_i,
        input  cf_pkg::sample_t sample_q,
        output logic            sample_ready,
        output logic            ratio_valid,
        output cf_pkg::tone_t   ratio_tone,
        output cf_pkg::ratio_t  ratio_value,
        output logic            cost_valid,
        output cf_pkg::cost_t   cost_value,
        output logic            sweep_busy
);
        import cf_pkg::*;

        // divider link
        logic   div_start;
        mag_t   div_num;
        mag_t   div_den;
        logic   div_done;
        ratio_t div_q;

        // end of cost sum, releases the controller
        logic   cost_done;

        ratio_bus_if rb ();

        sweep_ctrl u_sweep_ctrl (
                .clk          (clk),
                .rst          (rst),
                .sample_valid (sample_valid),
                .sample_i     (sample_i),
                .sample_q     (sample_q),
                .div_done     (div_done),
                .div_q        (div_q),
                .cost_done    (cost_done),
                .sample_ready (sample_ready),
                .sweep_busy   (sweep_busy),
                .div_start    (div_start),
                .div_num      (div_num),
                .div_den      (div_den),
                .rb           (rb.src)
        );

        gain_divider u_gain_divider (
                .clk       (clk),
                .rst       (rst),
                .div_start (div_start),
                .div_num   (div_num),
                .div_den   (div_den),
                .div_done  (div_done),
                .div_q     (div_q)
        );

        cost_accum u_cost_accum (
                .clk        (clk),
                .rst        (rst),
                .rb         (rb.dst),
                .cost_valid (cost_valid),
                .cost_value (cost_value),
                .cost_done  (cost_done)
        );

        // ratio report is the bus itself
        assign ratio_valid = rb.valid;
        assign ratio_tone  = rb.tone;
        assign ratio_value = rb.ratio;

endmodule

// ==== verilog/cost_accum.sv ====
/* keeps the four tone ratios of a sweep and sums the five cost terms,
   one term per cycle, after the last ratio arrives */
`timescale 1ns/1ps

module cost_accum (
        input  logic          clk,
        input  logic          rst,
        ratio_bus_if.dst      rb,
        output logic          cost_valid,
        output cf_pkg::cost_t cost_value,
        output logic          cost_done
);
        import cf_pkg::*;

        // wide enough for five full-scale terms
        typedef logic [$clog2(cost_terms * (ratio_max + 1))-1:0] sum_t;

        ratio_t     a [n_tones];
        logic       run;
        logic [2:0] idx;
        logic       last_term;
        sum_t       sum;
        sum_t       sum_nx;
        ratio_t     term;

        // x * 106 / 256, rounded down
        function automatic ratio_t tilt(input ratio_t x);
                logic [15:0] p;
                p = x * 8'(tilt_weight);
                return p[15:8];
        endfunction

        function automatic ratio_t abs_diff(input ratio_t x, input ratio_t y);
                return (x >= y) ? x - y : y - x;
        endfunction

        // --------------------------------------------------
        // ratio store, indexed by tone
        // --------------------------------------------------
        always_ff @(posedge clk) begin
                if (rb.valid)
                        a[rb.tone] <= rb.ratio;
        end

        // term order: tilt A3/A1, A1-A4, A2-A3, tilt A2/A4, mid-band A2
        always_comb begin
                case (idx)
                3'd0:    term = abs_diff(a[2], tilt(a[0]));
                3'd1:    term = abs_diff(a[0], a[3]);
                3'd2:    term = abs_diff(a[1], a[2]);
                3'd3:    term = abs_diff(a[1], tilt(a[3]));
                default: term = abs_diff(a[1], ratio_t'(unity_ratio));
                endcase
        end

        assign sum_nx    = sum + sum_t'(term);
        assign last_term = run && (idx == 3'(cost_terms - 1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        run        <= 1'b0;
                        idx        <= '0;
                        cost_valid <= 1'b0;
                end else begin
                        cost_valid <= last_term;
                        if (rb.valid && rb.last) begin
                                run <= 1'b1;
                                idx <= '0;
                        end else if (run) begin
                                idx <= idx + 3'd1;
                                if (last_term)
                                        run <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rb.valid && rb.last)
                        sum <= '0;
                else if (run)
                        sum <= sum_nx;
                if (last_term)
                        cost_value <= (sum_nx > sum_t'(cost_max)) ? cost_t'(cost_max) : sum_nx[7:0];
        end

        // also releases the sweep controller
        assign cost_done = cost_valid;

endmodule

// ==== verilog/gain_divider.sv ====
/* restoring shift-subtract divider for (num << 7) / den, one quotient bit per
   cycle; result saturates at 255 and a zero divisor also gives 255 */
`timescale 1ns/1ps

module gain_divider (
        input  logic           clk,
        input  logic           rst,
        input  logic           div_start,
        input  cf_pkg::mag_t   div_num,
        input  cf_pkg::mag_t   div_den,
        output logic           div_done,
        output cf_pkg::ratio_t div_q
);
        import cf_pkg::*;

        logic [div_steps-1:0] dvd;
        logic [div_steps-1:0] quo;
        logic [div_steps-1:0] quo_nx;
        mag_t                 rem;
        mag_t                 den;
        logic [3:0]           cnt;
        logic                 busy;
        logic                 last_step;
        logic [8:0]           rem_sh;
        logic [9:0]           trial;
        logic                 ge;

        // bring down the next dividend bit and try the subtraction
        assign rem_sh = {rem, dvd[div_steps-1]};
        assign trial  = {1'b0, rem_sh} - {2'b00, den};
        assign ge     = ~trial[9];
        assign quo_nx = {quo[div_steps-2:0], ge};

        assign last_step = busy && (cnt == 4'(div_steps - 1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        busy     <= 1'b0;
                        cnt      <= '0;
                        div_done <= 1'b0;
                end else begin
                        div_done <= last_step;
                        if (div_start) begin
                                busy <= 1'b1;
                                cnt  <= '0;
                        end else if (busy) begin
                                cnt <= cnt + 4'd1;
                                if (last_step)
                                        busy <= 1'b0;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (div_start) begin
                        dvd <= div_steps'(div_num) << ratio_shift;
                        quo <= '0;
                        rem <= '0;
                        den <= div_den;
                end else if (busy) begin
                        dvd <= dvd << 1;
                        rem <= ge ? trial[7:0] : rem_sh[7:0];
                        quo <= quo_nx;
                end
                // anything above 8 bits, or a zero divisor, clips to full scale
                if (last_step)
                        div_q <= (den == '0 || |quo_nx[div_steps-1:8]) ?
                                 ratio_t'(ratio_max) : quo_nx[7:0];
        end

endmodule

// ==== verilog/sweep_ctrl.sv ====
/* sweep controller; takes an output then an input sample per tone, estimates
   both magnitudes, starts the divider and reports each ratio on the ratio bus */
`timescale 1ns/1ps

module sweep_ctrl (
        input  logic            clk,
        input  logic            rst,
        input  logic            sample_valid,
        input  cf_pkg::sample_t sample_i,
        input  cf_pkg::sample_t sample_q,
        input  logic            div_done,
        input  cf_pkg::ratio_t  div_q,
        input  logic            cost_done,
        output logic            sample_ready,
        output logic            sweep_busy,
        output logic            div_start,
        output cf_pkg::mag_t    div_num,
        output cf_pkg::mag_t    div_den,
        ratio_bus_if.src        rb
);
        import cf_pkg::*;

        sweep_state_e state;
        tone_t        tone;
        mag_t         mag;
        logic         take;
        logic         ratio_hit;
        logic         last_tone;

        // -128 wraps onto 8'h80, i.e. 128 unsigned
        function automatic mag_t abs_val(input sample_t x);
                return x[7] ? mag_t'(-x) : mag_t'(x);
        endfunction

        // larger component plus half the smaller one
        function automatic mag_t mag_est(input sample_t si, input sample_t sq);
                mag_t a;
                mag_t b;
                a = abs_val(si);
                b = abs_val(sq);
                if (a >= b)
                        return a + (b >> 1);
                else
                        return b + (a >> 1);
        endfunction

        // --------------------------------------------------
        // sample acceptance
        // --------------------------------------------------
        assign sample_ready = (state == s_out) || (state == s_in);
        assign take         = sample_valid && sample_ready;
        assign mag          = mag_est(sample_i, sample_q);

        assign ratio_hit = div_done && (state == s_div);
        assign last_tone = (tone == tone_t'(n_tones - 1));

        always_ff @(posedge clk) begin
                if (rst) begin
                        state      <= s_out;
                        tone       <= '0;
                        sweep_busy <= 1'b0;
                        div_start  <= 1'b0;
                end else begin
                        // divider starts once both magnitudes are held
                        div_start <= take && (state == s_in);
                        if (take)
                                sweep_busy <= 1'b1;
                        else if (cost_done)
                                sweep_busy <= 1'b0;
                        case (state)
                        s_out: if (take) state <= s_in;
                        s_in:  if (take) state <= s_div;
                        s_div: begin
                                if (div_done) begin
                                        tone  <= last_tone ? '0 : tone + 2'd1;
                                        state <= last_tone ? s_cost : s_out;
                                end
                        end
                        s_cost: if (cost_done) state <= s_out;
                        default: state <= s_out;
                        endcase
                end
        end

        // output magnitude waits here for its input partner
        always_ff @(posedge clk) begin
                if (take && (state == s_out))
                        div_num <= mag;
                if (take && (state == s_in))
                        div_den <= mag;
        end

        // --------------------------------------------------
        // ratio report, same cycle as div_done
        // --------------------------------------------------
        assign rb.valid = ratio_hit;
        assign rb.tone  = tone;
        assign rb.ratio = div_q;
        assign rb.last  = ratio_hit && last_tone;

endmodule

// ==== verilog/ratio_bus_if.sv ====
/* one finished gain ratio, passed from the sweep controller to the cost accumulator */
`timescale 1ns/1ps

interface ratio_bus_if;
        import cf_pkg::*;

        // single-cycle strobe for the ratio below
        logic   valid;
        tone_t  tone;
        ratio_t ratio;
        // set together with the tone 3 strobe
        logic   last;

        modport src (output valid, output tone, output ratio, output last);

        modport dst (input valid, input tone, input ratio, input last);

endinterface

// ==== verilog/cf_pkg.sv ====
/* shared types and constants of the gain-flatness cost engine
   imported by every RTL block of the design */

package cf_pkg;

        // --------------------------------------------------
        // data widths
        // --------------------------------------------------
        typedef logic signed [7:0] sample_t;
        // max(|i|,|q|) + min/2, never above 192
        typedef logic [7:0]        mag_t;
        // 128 stands for unity gain
        typedef logic [7:0]        ratio_t;
        typedef logic [7:0]        cost_t;
        typedef logic [1:0]        tone_t;

        // sweep controller states
        typedef enum logic [1:0] {
                s_out,
                s_in,
                s_div,
                s_cost
        } sweep_state_e;

        // --------------------------------------------------
        // constants
        // --------------------------------------------------
        localparam int n_tones     = 4;
        localparam int ratio_shift = 7;
        localparam int div_steps   = 16;
        // 106/256 is close to 0.414
        localparam int tilt_weight = 106;
        localparam int unity_ratio = 128;
        localparam int ratio_max   = 255;
        localparam int cost_max    = 255;
        localparam int cost_terms  = 5;

endpackage
